// File: design/procyon_pkg.sv
// Shared widths, scalar types and packed structs for the rename core, imported by every module
`default_nettype none

package procyon_pkg;

    // Datapath and storage sizes
    localparam int DATA_WIDTH     = 32;
    localparam int REG_COUNT      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ROB_DEPTH      = 8;
    localparam int TAG_WIDTH      = 3;

    typedef logic [DATA_WIDTH-1:0]     procyon_data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] procyon_reg_t;

    // A tag is the index of the reorder buffer entry that will produce a value
    typedef logic [TAG_WIDTH-1:0]      procyon_tag_t;

    // Final answer for one source operand
    // When rdy is low the consumer waits for the result carrying tag
    typedef struct packed {
        logic          rdy;
        procyon_tag_t  tag;
        procyon_data_t data;
    } operand_t;

    // Reorder buffer reply to a lookup by tag
    typedef struct packed {
        logic          done;
        procyon_data_t data;
    } rob_query_t;

    // Instruction leaving the head of the reorder buffer this cycle
    typedef struct packed {
        logic          valid;
        procyon_reg_t  rdest;
        procyon_tag_t  tag;
        procyon_data_t data;
    } retire_t;

endpackage : procyon_pkg

`default_nettype wire

// File: design/register_map.sv
// Architectural register map holding committed data, latest producer tag and ready bit per register
`timescale 1ns/1ps
`default_nettype none

module register_map
    import procyon_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           n_rst,

    // Flush makes every register ready again with its committed value
    input  wire logic           i_flush,

    // Retiring instruction from the head of the reorder buffer
    input  wire retire_t        i_retire,

    // Rename write from an accepted dispatch
    input  wire procyon_tag_t   i_rename_tag,
    input  wire procyon_reg_t   i_rename_rdest,
    input  wire logic           i_rename_wr_en,

    // Two source lookups for the dispatching instruction
    input  wire procyon_reg_t   i_lookup_rsrc [0:1],
    output logic                o_lookup_rdy  [0:1],
    output procyon_tag_t        o_lookup_tag  [0:1],
    output procyon_data_t       o_lookup_data [0:1]
);

    // Register r0 has no storage at all, so only r1 and up are kept
    procyon_data_t              data_q [1:REG_COUNT-1];
    procyon_tag_t               tag_q  [1:REG_COUNT-1];
    logic [REG_COUNT-1:1]       rdy_q;

    logic                       rename_en;
    logic                       retire_en;

    // A destination of r0 means the result is thrown away
    assign rename_en = i_rename_wr_en && (i_rename_rdest != '0);
    assign retire_en = i_retire.valid && (i_retire.rdest != '0);

    // Lookups read the state as it was before this edge
    // A source equal to the renamed destination still sees the older producer
    for (genvar p = 0; p < 2; p++) begin : g_lookup
        always_comb begin
            if (i_lookup_rsrc[p] == '0) begin
                o_lookup_rdy[p]  = 1'b1;
                o_lookup_tag[p]  = '0;
                o_lookup_data[p] = '0;
            end else begin
                o_lookup_rdy[p]  = rdy_q[i_lookup_rsrc[p]];
                o_lookup_tag[p]  = tag_q[i_lookup_rsrc[p]];
                o_lookup_data[p] = data_q[i_lookup_rsrc[p]];
            end
        end
    end

    // Tags name the newest in-flight producer of each register
    always_ff @(posedge clk) begin
        for (int r = 1; r < REG_COUNT; r++) begin
            if (rename_en && (i_rename_rdest == procyon_reg_t'(r))) begin
                tag_q[r] <= i_rename_tag;
            end
        end
    end

    // Committed data follows retirement, which is always in program order
    // so every retire may overwrite the value even when a younger rename exists
    always_ff @(posedge clk) begin
        for (int r = 1; r < REG_COUNT; r++) begin
            if (retire_en && (i_retire.rdest == procyon_reg_t'(r))) begin
                data_q[r] <= i_retire.data;
            end
        end
    end

    // Ready bits come out of reset set, since nothing is in flight yet
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else if (i_flush) begin
            // All outstanding tags die with the flush and the map already holds
            // the last committed value of every register
            rdy_q <= '1;
        end else begin
            for (int r = 1; r < REG_COUNT; r++) begin
                if (rename_en && (i_rename_rdest == procyon_reg_t'(r))) begin
                    // A new producer wins over a retire to the same register
                    rdy_q[r] <= 1'b0;
                end else if (retire_en && (i_retire.rdest == procyon_reg_t'(r)) &&
                             (i_retire.tag == tag_q[r])) begin
                    // Only the newest producer makes the register ready again
                    rdy_q[r] <= 1'b1;
                end
            end
        end
    end

endmodule : register_map

`default_nettype wire

// File: design/reorder_buffer.sv
// Circular reorder buffer that hands out tags, records completions and retires in order
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import procyon_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           n_rst,
    input  wire logic           i_flush,

    // Dispatch side
    input  wire logic           i_dispatch_valid,
    input  wire procyon_reg_t   i_dispatch_rdest,

    // Completion written back by tag
    input  wire logic           i_complete_valid,
    input  wire procyon_tag_t   i_complete_tag,
    input  wire procyon_data_t  i_complete_data,

    // Lookups by tag for the two source operands
    input  wire procyon_tag_t   i_query_tag [0:1],

    output logic                o_full,
    output procyon_tag_t        o_alloc_tag,
    output logic                o_accept,
    output rob_query_t          o_query [0:1],
    output retire_t             o_retire
);

    // Control state per entry
    logic [ROB_DEPTH-1:0]       valid_q;
    logic [ROB_DEPTH-1:0]       done_q;

    // Payload per entry, kept like a small RAM
    procyon_reg_t               rdest_q [ROB_DEPTH];
    procyon_data_t              data_q  [ROB_DEPTH];

    procyon_tag_t               head_q;
    procyon_tag_t               tail_q;
    logic [TAG_WIDTH:0]         count_q;

    logic                       complete_en;
    logic                       retire_en;

    // Full while every entry holds an instruction
    assign o_full      = (count_q == (TAG_WIDTH+1)'(ROB_DEPTH));

    // The tail index is the tag of the next instruction
    assign o_alloc_tag = tail_q;

    // A flush swallows any dispatch seen in the same cycle
    assign o_accept    = i_dispatch_valid && !o_full && !i_flush;

    // Late or stray completions to empty entries are dropped
    assign complete_en = i_complete_valid && valid_q[i_complete_tag] && !i_flush;

    // The head leaves once its result is in, unless a flush cancels it
    assign retire_en   = valid_q[head_q] && done_q[head_q] && !i_flush;

    always_comb begin
        o_retire.valid = retire_en;
        o_retire.rdest = rdest_q[head_q];
        o_retire.tag   = head_q;
        o_retire.data  = data_q[head_q];
    end

    // Source lookups see completions from earlier edges only
    for (genvar p = 0; p < 2; p++) begin : g_query
        assign o_query[p].done = valid_q[i_query_tag[p]] && done_q[i_query_tag[p]];
        assign o_query[p].data = data_q[i_query_tag[p]];
    end

    // Entry status bits
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            // The tail is never the head of a live entry when accepting
            if (o_accept) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
            end
            if (complete_en) begin
                done_q[i_complete_tag] <= 1'b1;
            end
            if (retire_en) begin
                valid_q[head_q] <= 1'b0;
            end
        end
    end

    // Destination register is captured at dispatch
    always_ff @(posedge clk) begin
        if (o_accept) begin
            rdest_q[tail_q] <= i_dispatch_rdest;
        end
    end

    // Result data arrives out of order by tag
    always_ff @(posedge clk) begin
        if (complete_en) begin
            data_q[i_complete_tag] <= i_complete_data;
        end
    end

    // Pointers wrap naturally because the depth is a power of two
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (i_flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (o_accept) begin
                tail_q <= tail_q + procyon_tag_t'(1);
            end
            if (retire_en) begin
                head_q <= head_q + procyon_tag_t'(1);
            end
        end
    end

    // Occupancy, unchanged when one enters and one leaves together
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count_q <= '0;
        end else if (i_flush) begin
            count_q <= '0;
        end else begin
            case ({o_accept, retire_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: design/operand_resolver.sv
// Merges register map and reorder buffer lookups into the final answer for each source operand
`timescale 1ns/1ps
`default_nettype none

module operand_resolver
    import procyon_pkg::*;
(
    // Register map view of each source
    input  wire logic           i_map_rdy  [0:1],
    input  wire procyon_tag_t   i_map_tag  [0:1],
    input  wire procyon_data_t  i_map_data [0:1],

    // Reorder buffer state of the producer named by the map tag
    input  wire rob_query_t     i_query    [0:1],

    output operand_t            o_operand  [0:1]
);

    for (genvar p = 0; p < 2; p++) begin : g_resolve
        always_comb begin
            // The tag always names the newest producer known to the map
            o_operand[p].tag = i_map_tag[p];
            if (i_map_rdy[p]) begin
                // Committed value with no producer in flight
                o_operand[p].rdy  = 1'b1;
                o_operand[p].data = i_map_data[p];
            end else if (i_query[p].done) begin
                // Producer has finished but not yet retired, so forward its result
                o_operand[p].rdy  = 1'b1;
                o_operand[p].data = i_query[p].data;
            end else begin
                // The producer is still executing and the consumer waits on this tag
                o_operand[p].rdy  = 1'b0;
                o_operand[p].data = '0;
            end
        end
    end

endmodule : operand_resolver

`default_nettype wire

// File: design/rename_core.sv
// Top level of the rename core that ties the register map, reorder buffer and operand resolver together
`timescale 1ns/1ps
`default_nettype none

module rename_core
    import procyon_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           n_rst,
    input  wire logic           i_flush,

    // Dispatch of one instruction per cycle
    input  wire logic           i_dispatch_valid,
    input  wire procyon_reg_t   i_dispatch_rdest,
    input  wire procyon_reg_t   i_dispatch_rsrc [0:1],
    output logic                o_dispatch_full,
    output procyon_tag_t        o_dispatch_tag,
    output operand_t            o_operand [0:1],

    // Execution results by tag
    input  wire logic           i_complete_valid,
    input  wire procyon_tag_t   i_complete_tag,
    input  wire procyon_data_t  i_complete_data,

    // In-order retirement
    output retire_t             o_retire
);

    logic                       accept;
    procyon_tag_t               alloc_tag;
    logic                       map_rdy  [0:1];
    procyon_tag_t               map_tag  [0:1];
    procyon_data_t              map_data [0:1];
    rob_query_t                 rob_query [0:1];

    // The allocated tag goes out with the dispatch and into the map
    assign o_dispatch_tag = alloc_tag;

    // Renaming only happens for dispatches the reorder buffer really took
    register_map u_register_map (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_retire       (o_retire),
        .i_rename_tag   (alloc_tag),
        .i_rename_rdest (i_dispatch_rdest),
        .i_rename_wr_en (accept),
        .i_lookup_rsrc  (i_dispatch_rsrc),
        .o_lookup_rdy   (map_rdy),
        .o_lookup_tag   (map_tag),
        .o_lookup_data  (map_data)
    );

    // Map tags select which entries the reorder buffer reports on
    reorder_buffer u_reorder_buffer (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_dispatch_valid (i_dispatch_valid),
        .i_dispatch_rdest (i_dispatch_rdest),
        .i_complete_valid (i_complete_valid),
        .i_complete_tag   (i_complete_tag),
        .i_complete_data  (i_complete_data),
        .i_query_tag      (map_tag),
        .o_full           (o_dispatch_full),
        .o_alloc_tag      (alloc_tag),
        .o_accept         (accept),
        .o_query          (rob_query),
        .o_retire         (o_retire)
    );

    operand_resolver u_operand_resolver (
        .i_map_rdy  (map_rdy),
        .i_map_tag  (map_tag),
        .i_map_data (map_data),
        .i_query    (rob_query),
        .o_operand  (o_operand)
    );

endmodule : rename_core

`default_nettype wire

// File: tb/tb_rename_core.sv
// Self-checking testbench for the rename core, compiled with vlog.f and run with tb_rename_core as top
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core
    import procyon_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int DIRECTED_CYCLES = 400;
    localparam int RANDOM_CYCLES   = 500;
    localparam int MARGIN_CYCLES   = 100;

    logic          clk;
    logic          n_rst;
    logic          flush;
    logic          dispatch_valid;
    procyon_reg_t  dispatch_rdest;
    procyon_reg_t  dispatch_rsrc [0:1];
    logic          dispatch_full;
    procyon_tag_t  dispatch_tag;
    operand_t      operand [0:1];
    logic          complete_valid;
    procyon_tag_t  complete_tag;
    procyon_data_t complete_data;
    retire_t       retire;
    integer        seed;

    // Reference model state where committed values stay unknown until a register first retires
    procyon_data_t commit_val [0:REG_COUNT-1];
    procyon_tag_t  map_tag    [0:REG_COUNT-1];
    logic          map_rdy    [0:REG_COUNT-1];
    logic          ent_valid  [0:ROB_DEPTH-1];
    logic          ent_done   [0:ROB_DEPTH-1];
    procyon_reg_t  ent_rdest  [0:ROB_DEPTH-1];
    procyon_data_t ent_data   [0:ROB_DEPTH-1];
    procyon_tag_t  inflight   [$];
    procyon_tag_t  model_tail;

    rename_core u_dut (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (flush),
        .i_dispatch_valid (dispatch_valid),
        .i_dispatch_rdest (dispatch_rdest),
        .i_dispatch_rsrc  (dispatch_rsrc),
        .o_dispatch_full  (dispatch_full),
        .o_dispatch_tag   (dispatch_tag),
        .o_operand        (operand),
        .i_complete_valid (complete_valid),
        .i_complete_tag   (complete_tag),
        .i_complete_data  (complete_data),
        .o_retire         (retire)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_val(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Finished with errors");
        $fatal(1, "Run aborted");
    endtask

    // Expected answer for one source following the resolution rule
    function automatic operand_t expected_operand(input procyon_reg_t rsrc);
        operand_t op;
        op.rdy  = 1'b1;
        op.tag  = '0;
        op.data = '0;
        if (rsrc == '0) begin
            op.data = '0;
        end else if (map_rdy[rsrc]) begin
            op.data = commit_val[rsrc];
        end else if (ent_valid[map_tag[rsrc]] && ent_done[map_tag[rsrc]]) begin
            op.data = ent_data[map_tag[rsrc]];
        end else begin
            op.rdy = 1'b0;
            op.tag = map_tag[rsrc];
        end
        return op;
    endfunction

    task automatic clear_inflight();
        inflight.delete();
        for (int e = 0; e < ROB_DEPTH; e++) begin
            ent_valid[e] = 1'b0;
            ent_done[e]  = 1'b0;
        end
        model_tail = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            map_rdy[r] = 1'b1;
        end
    endtask

    // Compare every cycle against the model state, which mirrors the DUT after the last edge
    task automatic compare_outputs();
        operand_t exp_op;
        logic     exp_ret;
        check_val(dispatch_full, inflight.size() == ROB_DEPTH, "dispatch full flag");
        check_val(dispatch_tag, model_tail, "dispatch tag");
        for (int p = 0; p < 2; p++) begin
            exp_op = expected_operand(dispatch_rsrc[p]);
            check_val(operand[p].rdy, exp_op.rdy, $sformatf("ready of source %0d", p));
            if (!exp_op.rdy) begin
                check_val(operand[p].tag, exp_op.tag, $sformatf("tag of source %0d", p));
            end else if (!$isunknown(exp_op.data)) begin
                check_val(operand[p].data, exp_op.data, $sformatf("data of source %0d", p));
            end
        end
        exp_ret = !flush && (inflight.size() > 0) && ent_done[inflight[0]];
        check_val(retire.valid, exp_ret, "retire valid");
        if (exp_ret) begin
            check_val(retire.rdest, ent_rdest[inflight[0]], "retire rdest");
            check_val(retire.tag, inflight[0], "retire tag");
            check_val(retire.data, ent_data[inflight[0]], "retire data");
        end
    endtask

    // Apply the inputs that the next rising edge will sample
    task automatic advance_model();
        logic         accept;
        logic         retire_en;
        logic         complete_en;
        procyon_tag_t head;
        procyon_reg_t rd;
        accept      = dispatch_valid && (inflight.size() < ROB_DEPTH) && !flush;
        retire_en   = !flush && (inflight.size() > 0) && ent_done[inflight[0]];
        complete_en = complete_valid && ent_valid[complete_tag] && !flush;
        if (flush) begin
            clear_inflight();
        end else begin
            if (retire_en) begin
                head = inflight.pop_front();
                rd   = ent_rdest[head];
                ent_valid[head] = 1'b0;
                if (rd != '0) begin
                    commit_val[rd] = ent_data[head];
                    // A younger rename in this cycle keeps the register waiting
                    if (map_tag[rd] == head && !(accept && dispatch_rdest == rd)) begin
                        map_rdy[rd] = 1'b1;
                    end
                end
            end
            if (complete_en) begin
                ent_done[complete_tag] = 1'b1;
                ent_data[complete_tag] = complete_data;
            end
            if (accept) begin
                ent_valid[model_tail] = 1'b1;
                ent_done[model_tail]  = 1'b0;
                ent_rdest[model_tail] = dispatch_rdest;
                inflight.push_back(model_tail);
                if (dispatch_rdest != '0) begin
                    map_tag[dispatch_rdest] = model_tail;
                    map_rdy[dispatch_rdest] = 1'b0;
                end
                model_tail = model_tail + procyon_tag_t'(1);
            end
        end
    endtask

    always @(negedge clk) begin
        if (n_rst) begin
            compare_outputs();
            advance_model();
        end
    end

    task automatic drive(input logic dv, input procyon_reg_t rd, input procyon_reg_t rs0,
                         input procyon_reg_t rs1, input logic cv, input procyon_tag_t ct,
                         input procyon_data_t cd, input logic fl);
        @(posedge clk);
        dispatch_valid   <= dv;
        dispatch_rdest   <= rd;
        dispatch_rsrc[0] <= rs0;
        dispatch_rsrc[1] <= rs1;
        complete_valid   <= cv;
        complete_tag     <= ct;
        complete_data    <= cd;
        flush            <= fl;
    endtask

    task automatic lookup(input procyon_reg_t rs0, input procyon_reg_t rs1);
        drive(1'b0, '0, rs0, rs1, 1'b0, '0, '0, 1'b0);
    endtask

    // The tag is the model tail seen at the edge that launches the dispatch
    task automatic dispatch_op(input procyon_reg_t rd, input procyon_reg_t rs0,
                               input procyon_reg_t rs1, output procyon_tag_t tag);
        drive(1'b1, rd, rs0, rs1, 1'b0, '0, '0, 1'b0);
        tag = model_tail;
    endtask

    task automatic complete_op(input procyon_tag_t ct, input procyon_data_t cd);
        drive(1'b0, '0, dispatch_rsrc[0], dispatch_rsrc[1], 1'b1, ct, cd, 1'b0);
    endtask

    task automatic complete_pending();
        procyon_tag_t pending [$];
        // One idle cycle so the model catches up with the last driven inputs
        lookup(dispatch_rsrc[0], dispatch_rsrc[1]);
        foreach (inflight[i]) begin
            if (!ent_done[inflight[i]]) pending.push_back(inflight[i]);
        end
        foreach (pending[i]) begin
            complete_op(pending[i], $random(seed));
        end
    endtask

    task automatic wait_for_drain(input int max_cycles);
        int n;
        n = 0;
        while (inflight.size() != 0) begin
            if (n >= max_cycles) abort_run("Reorder buffer never drained");
            lookup(dispatch_rsrc[0], dispatch_rsrc[1]);
            n++;
        end
    endtask

    task automatic sweep_sources();
        for (int r = 0; r < REG_COUNT; r += 2) begin
            lookup(procyon_reg_t'(r), procyon_reg_t'(r + 1));
            @(negedge clk);
            check_val(operand[0].rdy & operand[1].rdy, 1'b1,
                      $sformatf("r%0d/r%0d ready", r, r + 1));
        end
    endtask

    // Small register range so that sources often hit in-flight producers
    task automatic random_step();
        procyon_tag_t pending [$];
        @(posedge clk);
        foreach (inflight[i]) begin
            if (!ent_done[inflight[i]]) pending.push_back(inflight[i]);
        end
        flush            <= ($unsigned($random(seed)) % 100) < 3;
        dispatch_valid   <= ($unsigned($random(seed)) % 3) != 0;
        dispatch_rdest   <= procyon_reg_t'($unsigned($random(seed)) % 8);
        dispatch_rsrc[0] <= procyon_reg_t'($unsigned($random(seed)) % 8);
        dispatch_rsrc[1] <= procyon_reg_t'($unsigned($random(seed)) % 8);
        complete_data    <= $random(seed);
        if (pending.size() > 0 && ($unsigned($random(seed)) % 4) != 0) begin
            complete_valid <= 1'b1;
            complete_tag   <= pending[$unsigned($random(seed)) % pending.size()];
        end else begin
            // Stray completions to empty or finished entries
            complete_valid <= ($random(seed) & 1) != 0;
            complete_tag   <= procyon_tag_t'($random(seed));
        end
    endtask

    initial begin
        #((DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        procyon_tag_t t;
        procyon_tag_t tb_tag;
        procyon_tag_t tags [0:ROB_DEPTH-1];
        int           n;
        seed = 32'hc154_8f9f;
        clk = 1'b0;
        n_rst = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_rdest = '0;
        dispatch_rsrc[0] = '0;
        dispatch_rsrc[1] = '0;
        complete_valid = 1'b0;
        complete_tag = '0;
        complete_data = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            commit_val[r] = (r == 0) ? '0 : 'x;
            map_tag[r]    = '0;
        end
        clear_inflight();
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;

        // Everything is ready out of reset, and r0 ignores a retire into it
        sweep_sources();
        dispatch_op(0, 0, 0, t);
        complete_op(t, 32'hdead_beef);
        wait_for_drain(10);
        lookup(0, 0);
        @(negedge clk);
        check_val(operand[0].data, 0, "r0 reads zero after a retire into it");

        // Give every register a known committed value
        for (int r = 1; r < REG_COUNT; r++) begin
            dispatch_op(procyon_reg_t'(r), procyon_reg_t'(r), 0, t);
            complete_op(t, 32'h5a00_0000 ^ (r * 32'h0103_0507));
        end
        wait_for_drain(10);

        // Renamed source waits, then forwards, then reads the committed value
        dispatch_op(5, 5, 0, t);
        lookup(5, 0);
        @(negedge clk);
        check_val(operand[0].rdy, 0, "r5 waits on its producer");
        check_val(operand[0].tag, t, "r5 producer tag");
        complete_op(t, 32'h0000_5555);
        lookup(5, 0);
        @(negedge clk);
        check_val({operand[0].rdy, operand[0].data}, {1'b1, 32'h0000_5555}, "r5 forwarded");
        check_val(retire.valid, 1, "r5 producer retiring");
        lookup(5, 0);
        @(negedge clk);
        check_val({operand[0].rdy, operand[0].data}, {1'b1, 32'h0000_5555}, "r5 committed");

        // Completions arrive out of order but retire in dispatch order
        for (int i = 0; i < 4; i++) begin
            dispatch_op(procyon_reg_t'(6 + i), 0, 0, tags[i]);
        end
        complete_op(tags[2], 32'h0000_0a08);
        complete_op(tags[0], 32'h0000_0a06);
        complete_op(tags[3], 32'h0000_0a09);
        complete_op(tags[1], 32'h0000_0a07);
        wait_for_drain(10);

        // Two renames of r10 where only the younger one makes it ready
        dispatch_op(10, 0, 0, t);
        dispatch_op(10, 10, 0, tb_tag);
        complete_op(t, 32'h0000_a010);
        repeat (3) lookup(10, 0);
        @(negedge clk);
        check_val(operand[0].rdy, 0, "r10 still waits after the older retire");
        check_val(operand[0].tag, tb_tag, "r10 waits on the younger tag");
        complete_op(tb_tag, 32'h0000_b010);
        wait_for_drain(10);
        lookup(10, 0);
        @(negedge clk);
        check_val({operand[0].rdy, operand[0].data}, {1'b1, 32'h0000_b010}, "r10 younger value");

        // A full buffer bounces a ninth dispatch until one retire frees a slot
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_op(procyon_reg_t'(11 + i), 0, 0, tags[i]);
        end
        dispatch_op(19, 0, 0, t);
        @(negedge clk);
        check_val(dispatch_full, 1, "buffer full after eight dispatches");
        complete_op(tags[0], 32'h0000_f011);
        n = 0;
        @(negedge clk);
        while (dispatch_full) begin
            if (n >= 10) abort_run("Dispatch full never dropped after a retire");
            lookup(0, 0);
            @(negedge clk);
            n++;
        end
        check_val(dispatch_tag, tags[0], "tail reuses the retired slot");
        complete_pending();
        wait_for_drain(20);

        // Flush with work in flight and a finished head that would otherwise retire
        dispatch_op(20, 0, 0, tags[0]);
        dispatch_op(21, 20, 0, tags[1]);
        dispatch_op(22, 21, 0, tags[2]);
        complete_op(tags[1], 32'h0000_dead);
        complete_op(tags[0], 32'h0000_0a20);
        drive(1'b0, '0, 20, 21, 1'b0, '0, '0, 1'b1);
        lookup(20, 21);
        @(negedge clk);
        check_val(retire.valid, 0, "no retire after flush");
        check_val(dispatch_tag, 0, "buffer restarts at tag 0");
        sweep_sources();

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_step();
        end
        complete_pending();
        wait_for_drain(20);
        sweep_sources();

        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_rename_core

`default_nettype wire

// File: vlog.f
design/procyon_pkg.sv
design/register_map.sv
design/reorder_buffer.sv
design/operand_resolver.sv
design/rename_core.sv
tb/tb_rename_core.sv
